//--- event_ingress.f
+incdir+src
src/event_ingress_pkg.sv
src/link_gate.sv
src/beat_stats.sv
src/start_select.sv
src/ctrl_regs.sv
src/event_ingress_top.sv
verification/event_ingress_tb.sv

//--- Bender.yml
package:
  name: event_ingress

export_include_dirs:
  - src

sources:
  - src/event_ingress_pkg.sv
  - src/link_gate.sv
  - src/beat_stats.sv
  - src/start_select.sv
  - src/ctrl_regs.sv
  - src/event_ingress_top.sv
  - target: test
    files:
      - verification/event_ingress_tb.sv

//--- verification/event_ingress_tb.sv
`timescale 1ns/1ns
`include "event_ingress_cfg.svh"

module event_ingress_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 2000;

    logic                                              aclk;
    logic                                              arst_n_i;
    logic                                              event_open_i;
    event_ingress_pkg::link_beat_t [`EI_NUM_LINKS-1:0] s_link_i;
    logic [`EI_NUM_LINKS-1:0]                          s_ready_o;
    event_ingress_pkg::link_beat_t [`EI_NUM_LINKS-1:0] m_link_o;
    logic [`EI_NUM_LINKS-1:0]                          m_ready_i;
    event_ingress_pkg::reg_req_t                       req_i;
    event_ingress_pkg::reg_rsp_t                       rsp_o;
    logic                                              start_o;

    // reference model state
    event_ingress_pkg::beat_cnt_t  tally [`EI_NUM_LINKS];
    event_ingress_pkg::beat_cnt_t  exp_starts;
    event_ingress_pkg::link_mask_t cur_mask;

    event_ingress_top dut0 (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .event_open_i (event_open_i),
        .s_link_i     (s_link_i),
        .s_ready_o    (s_ready_o),
        .m_link_o     (m_link_o),
        .m_ready_i    (m_ready_i),
        .req_i        (req_i),
        .rsp_o        (rsp_o),
        .start_o      (start_o)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $fatal(1);
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input event_ingress_pkg::reg_data_t got, exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_beat(input string name, input event_ingress_pkg::link_beat_t got, exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_cnt(input string name, input event_ingress_pkg::beat_cnt_t got, exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_ready(input string name, input logic [`EI_NUM_LINKS-1:0] got, exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////
    // bus and link helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic drive_idle();
        s_link_i  = '0;
        m_ready_i = '0;
    endtask

    // response is due exactly one cycle after the strobe
    task automatic reg_access(input logic wr, input event_ingress_pkg::reg_addr_t addr,
                              input event_ingress_pkg::reg_sel_t sel,
                              input event_ingress_pkg::reg_data_t wdata,
                              output event_ingress_pkg::reg_data_t rdata);
        next_cycle();
        req_i.strobe = 1'b1;
        req_i.write  = wr;
        req_i.addr   = addr;
        req_i.sel    = sel;
        req_i.wdata  = wdata;
        next_cycle();
        req_i = '0;
        #1;
        if (rsp_o.valid !== 1'b1) begin
            fail_now($sformatf("no register response in the cycle after the strobe to %0d", addr));
        end
        rdata = rsp_o.rdata;
    endtask

    task automatic read_expect(input event_ingress_pkg::reg_addr_t addr,
                               input event_ingress_pkg::reg_data_t exp);
        event_ingress_pkg::reg_data_t rdata;
        reg_access(1'b0, addr, '0, '0, rdata);
        check_data($sformatf("rsp_o.rdata at address %0d", addr), rdata, exp);
    endtask

    task automatic write_ctrl(input event_ingress_pkg::reg_sel_t sel,
                              input event_ingress_pkg::reg_data_t wdata);
        event_ingress_pkg::reg_data_t rdata;
        reg_access(1'b1, 4'd0, sel, wdata, rdata);
        check_data("rsp_o.rdata on write", rdata, '0);
        if (sel[1]) begin
            cur_mask = wdata[11:8];
        end
    endtask

    task automatic check_counts();
        event_ingress_pkg::reg_data_t rdata;
        for (int k = 0; k < `EI_NUM_LINKS; k++) begin
            reg_access(1'b0, 4'(4 + k), '0, '0, rdata);
            check_cnt($sformatf("beat_cnt[%0d]", k), rdata, tally[k]);
        end
        reg_access(1'b0, 4'd1, '0, '0, rdata);
        check_cnt("start_cnt", rdata, exp_starts);
    endtask

    // lowest link with a clear mask bit decides
    function automatic logic start_due(input event_ingress_pkg::link_mask_t mask,
                                       input event_ingress_pkg::beat_vec_t lasts);
        for (int k = 0; k < `EI_NUM_LINKS; k++) begin
            if (!mask[k]) begin
                return lasts[k];
            end
        end
        return 1'b0;
    endfunction

    // random traffic on open links
    // two idle cycles at the end drain the start pipe
    task automatic run_traffic(input int cycles, input logic counting);
        event_ingress_pkg::beat_vec_t lasts;
        logic [1:0]                   due;
        logic [31:0]                  rnd;
        due = 2'b00;
        for (int c = 0; c < cycles + 2; c++) begin
            next_cycle();
            lasts     = '0;
            rnd       = $urandom;
            m_ready_i = (c < cycles) ? rnd[`EI_NUM_LINKS-1:0] : '0;
            for (int k = 0; k < `EI_NUM_LINKS; k++) begin
                rnd               = $urandom;
                s_link_i[k].data  = $urandom;
                s_link_i[k].valid = (c < cycles) && rnd[0];
                s_link_i[k].last  = rnd[1];
                if (s_link_i[k].valid && m_ready_i[k]) begin
                    lasts[k] = s_link_i[k].last;
                    if (counting) begin
                        tally[k]++;
                    end
                end
            end
            #1;
            for (int k = 0; k < `EI_NUM_LINKS; k++) begin
                check_beat($sformatf("m_link_o[%0d]", k), m_link_o[k], s_link_i[k]);
            end
            check_ready("s_ready_o", s_ready_o, m_ready_i);
            if (due[1] && start_o !== 1'b1) begin
                fail_now("start pulse missing two cycles after a selected last beat");
            end
            check_bit("start_o", start_o, due[1]);
            if (due[1]) begin
                exp_starts++;
            end
            due = {due[0], counting & start_due(cur_mask, lasts)};
        end
    endtask

    task automatic last_on_link(input int k);
        event_ingress_pkg::beat_vec_t one_hot;
        logic                         due;
        one_hot    = '0;
        one_hot[k] = 1'b1;
        due        = start_due(cur_mask, one_hot);
        next_cycle();
        s_link_i[k].data  = $urandom;
        s_link_i[k].valid = 1'b1;
        s_link_i[k].last  = 1'b1;
        m_ready_i         = '1;
        tally[k]++;
        next_cycle();
        drive_idle();
        #1;
        check_bit("start_o", start_o, 1'b0);
        next_cycle();
        if (due && start_o !== 1'b1) begin
            fail_now($sformatf("no start pulse after the last beat on link %0d", k));
        end
        check_bit("start_o", start_o, due);
        if (due) begin
            exp_starts++;
        end
        next_cycle();
        check_bit("start_o", start_o, 1'b0);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_reset_defaults();
        check_ready("s_ready_o", s_ready_o, '1);
        check_bit("start_o", start_o, 1'b0);
        for (int a = 0; a < 8; a++) begin
            read_expect(4'(a), '0);
        end
    endtask

    task automatic test_closed_gating();
        logic [31:0] rnd;
        for (int c = 0; c < 40; c++) begin
            next_cycle();
            rnd       = $urandom;
            m_ready_i = rnd[`EI_NUM_LINKS-1:0];
            for (int k = 0; k < `EI_NUM_LINKS; k++) begin
                rnd               = $urandom;
                s_link_i[k].data  = $urandom;
                s_link_i[k].valid = 1'b1;
                s_link_i[k].last  = rnd[0];
            end
            #1;
            for (int k = 0; k < `EI_NUM_LINKS; k++) begin
                check_bit($sformatf("m_link_o[%0d].valid", k), m_link_o[k].valid, 1'b0);
            end
            check_ready("s_ready_o", s_ready_o, '1);
            check_bit("start_o", start_o, 1'b0);
        end
        drive_idle();
        check_counts();
    endtask

    task automatic test_open_stats();
        next_cycle();
        event_open_i = 1'b1;
        run_traffic(200, 1'b1);
        check_counts();
    endtask

    task automatic test_start_masks();
        event_ingress_pkg::link_mask_t masks [4];
        masks = '{4'b0000, 4'b0001, 4'b0110, 4'b1111};
        for (int m = 0; m < 4; m++) begin
            // reset bit set in wdata but lane 0 disabled
            write_ctrl(4'b0010, {20'h0, masks[m], 8'h01});
            read_expect(4'd0, {20'h0, masks[m], 8'h00});
            for (int k = 0; k < `EI_NUM_LINKS; k++) begin
                last_on_link(k);
            end
        end
        check_counts();
    endtask

    task automatic test_soft_reset();
        write_ctrl(4'b0010, 32'h0000_0200);
        // lane 1 disabled so the all-ones mask in wdata must not land
        write_ctrl(4'b0001, 32'hffff_ff01);
        read_expect(4'd0, 32'h0000_0201);
        for (int k = 0; k < `EI_NUM_LINKS; k++) begin
            tally[k] = '0;
        end
        exp_starts = '0;
        run_traffic(60, 1'b0);
        check_counts();
        write_ctrl(4'b0001, 32'h0000_0000);
        read_expect(4'd0, 32'h0000_0200);
        run_traffic(120, 1'b1);
        check_counts();
    endtask

    initial begin
        void'($urandom(32'h69a939c3));
        arst_n_i     = 1'b0;
        event_open_i = 1'b0;
        s_link_i     = '0;
        m_ready_i    = '0;
        req_i        = '0;
        exp_starts   = '0;
        cur_mask     = '0;
        for (int k = 0; k < `EI_NUM_LINKS; k++) begin
            tally[k] = '0;
        end
        repeat (10) @(posedge aclk);
        #1;
        arst_n_i = 1'b1;
        test_reset_defaults();
        test_closed_gating();
        test_open_stats();
        test_start_masks();
        test_soft_reset();
        $display("test passed");
        $finish;
    end

endmodule

//--- src/event_ingress_top.sv
`timescale 1ns/1ns
`include "event_ingress_cfg.svh"

module event_ingress_top (
    input  logic                                           aclk,
    input  logic                                           arst_n_i,
    input  logic                                           event_open_i,
    input  event_ingress_pkg::link_beat_t [`EI_NUM_LINKS-1:0] s_link_i,
    output logic [`EI_NUM_LINKS-1:0]                       s_ready_o,
    output event_ingress_pkg::link_beat_t [`EI_NUM_LINKS-1:0] m_link_o,
    input  logic [`EI_NUM_LINKS-1:0]                       m_ready_i,
    input  event_ingress_pkg::reg_req_t                    req_i,
    output event_ingress_pkg::reg_rsp_t                    rsp_o,
    output logic                                           start_o
);

    event_ingress_pkg::beat_vec_t                      beat_vec;
    event_ingress_pkg::beat_vec_t                      last_vec;
    event_ingress_pkg::beat_cnt_t [`EI_NUM_LINKS-1:0]  beat_cnt;
    event_ingress_pkg::beat_cnt_t                      start_cnt;
    event_ingress_pkg::link_mask_t                     link_mask;
    logic                                              soft_rst;

    ////////////////////
    // link ingress
    ////////////////////

    link_gate u_gate (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .event_open_i (event_open_i),
        .s_link_i     (s_link_i),
        .s_ready_o    (s_ready_o),
        .m_link_o     (m_link_o),
        .m_ready_i    (m_ready_i),
        .beat_o       (beat_vec),
        .last_o       (last_vec)
    );

    ////////////////////
    // bookkeeping
    ////////////////////

    beat_stats u_stats (
        .aclk       (aclk),
        .arst_n_i   (arst_n_i),
        .soft_rst_i (soft_rst),
        .beat_i     (beat_vec),
        .cnt_o      (beat_cnt)
    );

    // start event follows the lowest unmasked link
    start_select u_start (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .soft_rst_i  (soft_rst),
        .mask_i      (link_mask),
        .last_i      (last_vec),
        .start_o     (start_o),
        .start_cnt_o (start_cnt)
    );

    ////////////////////
    // register bank
    ////////////////////

    ctrl_regs u_regs (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .rsp_o       (rsp_o),
        .cnt_i       (beat_cnt),
        .start_cnt_i (start_cnt),
        .soft_rst_o  (soft_rst),
        .mask_o      (link_mask)
    );

endmodule

//--- src/ctrl_regs.sv
`timescale 1ns/1ns
`include "event_ingress_cfg.svh"

module ctrl_regs (
    input  logic                                          aclk,
    input  logic                                          arst_n_i,
    input  event_ingress_pkg::reg_req_t                   req_i,
    output event_ingress_pkg::reg_rsp_t                   rsp_o,
    input  event_ingress_pkg::beat_cnt_t [`EI_NUM_LINKS-1:0] cnt_i,
    input  event_ingress_pkg::beat_cnt_t                  start_cnt_i,
    output logic                                          soft_rst_o,
    output event_ingress_pkg::link_mask_t                 mask_o
);

    logic                          soft_rst_q;
    event_ingress_pkg::link_mask_t mask_q;
    event_ingress_pkg::reg_data_t  ctrl_word;
    event_ingress_pkg::reg_data_t  rd_data;
    event_ingress_pkg::reg_data_t  rdata_q;
    logic                          rsp_valid_q;
    logic [2:0]                    word_sel;
    logic                          wr_ctrl;

    // top address bit is a don't care
    assign word_sel = req_i.addr[2:0];
    assign wr_ctrl  = req_i.strobe & req_i.write & (word_sel == 3'd0);

    ////////////////////
    // control word
    ////////////////////

    // byte lane 0 carries the soft reset, lane 1 the link mask
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            soft_rst_q <= 1'b0;
            mask_q     <= '0;
        end else if (wr_ctrl) begin
            if (req_i.sel[0]) begin
                soft_rst_q <= req_i.wdata[0];
            end
            if (req_i.sel[1]) begin
                mask_q <= req_i.wdata[11:8];
            end
        end
    end

    always_comb begin
        ctrl_word       = '0;
        ctrl_word[0]    = soft_rst_q;
        ctrl_word[11:8] = mask_q;
    end

    ////////////////////
    // readback map
    ////////////////////

    // beat counts sit at 4..7, start count at 1, writes answer zero
    always_comb begin
        rd_data = '0;
        if (!req_i.write) begin
            case (word_sel)
                3'd0:                   rd_data = ctrl_word;
                3'd1:                   rd_data = start_cnt_i;
                3'd4, 3'd5, 3'd6, 3'd7: rd_data = cnt_i[word_sel[1:0]];
                default:                rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.strobe;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_i.strobe) begin
            rdata_q <= rd_data;
        end
    end

    always_comb begin
        rsp_o.valid = rsp_valid_q;
        rsp_o.rdata = rdata_q;
    end

    assign soft_rst_o = soft_rst_q;
    assign mask_o     = mask_q;

    // every answer traces back to a strobe one cycle earlier
    a_rsp_after_strobe : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        rsp_o.valid |-> $past(req_i.strobe)
    );

endmodule

//--- src/start_select.sv
`timescale 1ns/1ns
`include "event_ingress_cfg.svh"

module start_select (
    input  logic                         aclk,
    input  logic                         arst_n_i,
    input  logic                         soft_rst_i,
    input  event_ingress_pkg::link_mask_t mask_i,
    input  event_ingress_pkg::beat_vec_t  last_i,
    output logic                         start_o,
    output event_ingress_pkg::beat_cnt_t  start_cnt_o
);

    event_ingress_pkg::beat_vec_t last_q;
    event_ingress_pkg::beat_cnt_t start_cnt_q;
    logic                         sel_last;
    logic                         start_q;

    ////////////////////
    // last beat capture
    ////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q <= '0;
        end else begin
            last_q <= soft_rst_i ? '0 : last_i;
        end
    end

    // walk down so the lowest unmasked link is the one left standing
    always_comb begin
        sel_last = 1'b0;
        for (int k = `EI_NUM_LINKS - 1; k >= 0; k--) begin
            if (!mask_i[k]) begin
                sel_last = last_q[k];
            end
        end
    end

    ////////////////////
    // strobe and count
    ////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q     <= 1'b0;
            start_cnt_q <= '0;
        end else begin
            start_q <= sel_last & ~soft_rst_i;
            if (soft_rst_i) begin
                start_cnt_q <= '0;
            end else if (start_q) begin
                start_cnt_q <= start_cnt_q + 1'b1;
            end
        end
    end

    assign start_o     = start_q;
    assign start_cnt_o = start_cnt_q;

    // mask applies at selection, one cycle ahead of the strobe
    a_all_masked : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        (&mask_i) |=> !start_o
    );

endmodule

//--- src/beat_stats.sv
`timescale 1ns/1ns
`include "event_ingress_cfg.svh"

module beat_stats (
    input  logic                                          aclk,
    input  logic                                          arst_n_i,
    input  logic                                          soft_rst_i,
    input  event_ingress_pkg::beat_vec_t                  beat_i,
    output event_ingress_pkg::beat_cnt_t [`EI_NUM_LINKS-1:0] cnt_o
);

    event_ingress_pkg::beat_cnt_t [`EI_NUM_LINKS-1:0] cnt_q;

    ////////////////////
    // per-link counters
    ////////////////////

    // wrap silently at full scale
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else begin
            for (int k = 0; k < `EI_NUM_LINKS; k++) begin
                if (soft_rst_i) begin
                    cnt_q[k] <= '0;
                end else if (beat_i[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
        end
    end

    assign cnt_o = cnt_q;

    // the soft reset wins over any beat seen in the same cycle
    a_soft_rst_holds : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        soft_rst_i |=> (cnt_o == '0)
    );

endmodule

//--- src/link_gate.sv
`timescale 1ns/1ns
`include "event_ingress_cfg.svh"

module link_gate (
    input  logic                                           aclk,
    input  logic                                           arst_n_i,
    input  logic                                           event_open_i,
    input  event_ingress_pkg::link_beat_t [`EI_NUM_LINKS-1:0] s_link_i,
    output logic [`EI_NUM_LINKS-1:0]                       s_ready_o,
    output event_ingress_pkg::link_beat_t [`EI_NUM_LINKS-1:0] m_link_o,
    input  logic [`EI_NUM_LINKS-1:0]                       m_ready_i,
    output event_ingress_pkg::beat_vec_t                   beat_o,
    output event_ingress_pkg::beat_vec_t                   last_o
);

    logic open_q;

    ////////////////////
    // event open flag
    ////////////////////

    // one register stage, so open/close lands a cycle late
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            open_q <= 1'b0;
        end else begin
            open_q <= event_open_i;
        end
    end

    ////////////////////
    // gating
    ////////////////////

    // closed links swallow everything: ready forced high, valid masked off
    always_comb begin
        for (int k = 0; k < `EI_NUM_LINKS; k++) begin
            m_link_o[k]       = s_link_i[k];
            m_link_o[k].valid = s_link_i[k].valid & open_q;
            s_ready_o[k]      = m_ready_i[k] | ~open_q;
        end
    end

    // a beat counts only when it actually leaves downstream
    always_comb begin
        for (int k = 0; k < `EI_NUM_LINKS; k++) begin
            beat_o[k] = open_q & s_link_i[k].valid & m_ready_i[k];
            last_o[k] = open_q & s_link_i[k].valid & m_ready_i[k] & s_link_i[k].last;
        end
    end

    // input closed on the previous edge means every link drains this cycle
    a_closed_drains : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        !$past(event_open_i) |-> (&s_ready_o)
    );

endmodule

//--- src/event_ingress_pkg.sv
`include "event_ingress_cfg.svh"

package event_ingress_pkg;

    ////////////////////
    // link side
    ////////////////////

    typedef logic [`EI_LINK_DW-1:0] link_data_t;

    // set bit drops the link from start selection
    typedef logic [`EI_NUM_LINKS-1:0] link_mask_t;

    // one flag per link, high on a delivered beat
    typedef logic [`EI_NUM_LINKS-1:0] beat_vec_t;

    typedef logic [`EI_CNT_W-1:0] beat_cnt_t;

    typedef struct packed {
        link_data_t data;
        logic       valid;
        logic       last;
    } link_beat_t;

    ////////////////////
    // register bus
    ////////////////////

    typedef logic [`EI_REG_AW-1:0] reg_addr_t;
    typedef logic [`EI_REG_DW-1:0] reg_data_t;
    typedef logic [`EI_REG_DW/8-1:0] reg_sel_t;

    typedef struct packed {
        logic      strobe;
        logic      write;
        reg_addr_t addr;
        reg_sel_t  sel;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic      valid;
        reg_data_t rdata;
    } reg_rsp_t;

endpackage

//--- src/event_ingress_cfg.svh
`ifndef EVENT_INGRESS_CFG_SVH
`define EVENT_INGRESS_CFG_SVH

// number of detector links into the builder
`define EI_NUM_LINKS 4

// payload width of one link beat
`define EI_LINK_DW 32

// width of the beat and start counters
`define EI_CNT_W 32

// register bus word address width
`define EI_REG_AW 4

// register bus data width
`define EI_REG_DW 32

`endif
